//--- hdl/matrix_pkg.sv
package matrix_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // matrix payload
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [0:3][31:0] row_t;            // four floats, element 0 in top word
    typedef row_t [0:3] matrix_t;               // row 0 in top 128 bits

    ////////////////////////////////////////////////////////////////////////////
    // host commands and stack operations
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0]
    {
        OP_NOP     = 3'd0,
        OP_LOAD    = 3'd1,                      // one row per cycle, four cycles
        OP_POP     = 3'd2,
        OP_LOAD_ID = 3'd3,
        OP_WRITE   = 3'd4                       // all four rows at once
    } mat_opcode_t;

    typedef enum logic [1:0]
    {
        KIND_NONE = 2'd0,
        KIND_PUSH = 2'd1,
        KIND_POP  = 2'd2,
        KIND_SET  = 2'd3                        // overwrite top in place
    } mat_kind_t;

    typedef struct packed
    {
        logic      valid;
        mat_kind_t kind;
        logic      mode;                        // 0 modelview, 1 projection
        matrix_t   matrix;
    } mat_op_t;

    typedef struct packed
    {
        logic    valid;
        logic    mode;
        logic    err;                           // addressed stack refused the op
        matrix_t mv_top;
        matrix_t pj_top;
    } mat_status_t;

    ////////////////////////////////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int STACK_DEPTH = 2;             // matrices per stack
    localparam int DEPTH_W     = 2;             // holds 0..STACK_DEPTH

    localparam matrix_t IDENTITY =
    {
        128'h3F800000_00000000_00000000_00000000,
        128'h00000000_3F800000_00000000_00000000,
        128'h00000000_00000000_3F800000_00000000,
        128'h00000000_00000000_00000000_3F800000
    };

endpackage

//--- hdl/matrix_cmd_decode.sv
module matrix_cmd_decode
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cmd_valid,
    input  matrix_pkg::mat_opcode_t cmd_op,
    input  logic                    cmd_mode,
    input  matrix_pkg::matrix_t     cmd_rows,
    output matrix_pkg::mat_op_t     op
);

    logic [1:0]             row_cnt;            // load rows already collected
    logic                   load_mode;          // mode the partial load began in
    matrix_pkg::row_t [0:2] asm_rows;           // rows 0..2 wait here for row 3
    logic                   restart;
    logic [1:0]             row_idx;
    matrix_pkg::mat_op_t    op_d;

    // a mode change mid-load drops the partial rows, this row becomes row 0
    assign restart = (row_cnt != 2'd0) && (cmd_mode != load_mode);
    assign row_idx = restart ? 2'd0 : row_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // opcode to stack op
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        op_d.valid  = cmd_valid;
        op_d.kind   = matrix_pkg::KIND_NONE;
        op_d.mode   = cmd_mode;
        op_d.matrix = cmd_rows;                 // write uses all four rows as is
        case (cmd_op)
            matrix_pkg::OP_LOAD:
            begin
                op_d.valid  = cmd_valid && (row_idx == 2'd3);   // push on last row only
                op_d.kind   = matrix_pkg::KIND_PUSH;
                op_d.matrix = {asm_rows[0], asm_rows[1], asm_rows[2], cmd_rows[0]};
            end
            matrix_pkg::OP_POP:
                op_d.kind = matrix_pkg::KIND_POP;
            matrix_pkg::OP_LOAD_ID:
            begin
                op_d.kind   = matrix_pkg::KIND_SET;
                op_d.matrix = matrix_pkg::IDENTITY;
            end
            matrix_pkg::OP_WRITE:
                op_d.kind = matrix_pkg::KIND_SET;
            default:
                op_d.kind = matrix_pkg::KIND_NONE;  // nop and spare codes
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // row assembly and op register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            row_cnt  <= 2'd0;
            op.valid <= 1'b0;
        end
        else
        begin
            op <= op_d;
            if (cmd_valid)
            begin
                if (cmd_op == matrix_pkg::OP_LOAD)
                begin
                    row_cnt   <= row_idx + 2'd1;    // wraps to 0 after row 3
                    load_mode <= cmd_mode;
                    if (row_idx != 2'd3)
                        asm_rows[row_idx] <= cmd_rows[0];
                end
                else
                    row_cnt <= 2'd0;            // any other command abandons the load
            end
        end
    end

endmodule

//--- hdl/matrix_stack.sv
module matrix_stack
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  matrix_pkg::mat_kind_t kind,
    input  logic                  en,
    input  matrix_pkg::matrix_t   matrix,
    output matrix_pkg::matrix_t   top,
    output logic                  refused
);

    typedef logic [matrix_pkg::DEPTH_W-1:0] depth_t;

    matrix_pkg::matrix_t mem [matrix_pkg::STACK_DEPTH];   // slot 0 is the base
    depth_t              depth;                 // matrices held, never below 1
    depth_t              wr_idx;
    logic                full;
    logic                last;                  // only the base matrix left
    logic                do_push;
    logic                do_pop;
    logic                do_set;

    assign full = (depth == depth_t'(matrix_pkg::STACK_DEPTH));
    assign last = (depth == depth_t'(1));

    ////////////////////////////////////////////////////////////////////////////
    // op qualification
    ////////////////////////////////////////////////////////////////////////////

    assign do_push = en && (kind == matrix_pkg::KIND_PUSH) && !full;
    assign do_pop  = en && (kind == matrix_pkg::KIND_POP) && !last;
    assign do_set  = en && (kind == matrix_pkg::KIND_SET);

    // refused ops leave storage and depth alone
    assign refused = en && (((kind == matrix_pkg::KIND_PUSH) && full) ||
                            ((kind == matrix_pkg::KIND_POP) && last));

    // push lands above the top, set lands on it
    assign wr_idx = do_push ? depth : depth - depth_t'(1);

    ////////////////////////////////////////////////////////////////////////////
    // storage and depth counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            depth  <= depth_t'(1);
            mem[0] <= matrix_pkg::IDENTITY;     // one identity at reset
        end
        else
        begin
            for (int i = 0; i < matrix_pkg::STACK_DEPTH; i++)
            begin
                if ((do_push || do_set) && (i == int'(wr_idx)))
                    mem[i] <= matrix;
            end
            if (do_push)
                depth <= depth + depth_t'(1);
            else if (do_pop)
                depth <= depth - depth_t'(1);   // popped slot just goes stale
        end
    end

    // top of stack, plain mux on depth
    always_comb
    begin
        top = mem[0];
        for (int i = 1; i < matrix_pkg::STACK_DEPTH; i++)
        begin
            if (i == int'(depth) - 1)
                top = mem[i];
        end
    end

endmodule

//--- hdl/matrix_exec.sv
module matrix_exec
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  matrix_pkg::mat_op_t     op,
    output matrix_pkg::mat_status_t status
);

    logic                en_mv;
    logic                en_pj;
    logic                refused_mv;
    logic                refused_pj;
    matrix_pkg::matrix_t top_mv;
    matrix_pkg::matrix_t top_pj;
    logic                st_valid;
    logic                st_mode;
    logic                st_err;

    // only the addressed stack sees the op
    assign en_mv = op.valid && !op.mode;
    assign en_pj = op.valid && op.mode;

    ////////////////////////////////////////////////////////////////////////////
    // the two stacks
    ////////////////////////////////////////////////////////////////////////////

    matrix_stack u_modelview
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .kind    (op.kind),
        .en      (en_mv),
        .matrix  (op.matrix),                   // identity already filled in by decode
        .top     (top_mv),
        .refused (refused_mv)
    );

    matrix_stack u_projection
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .kind    (op.kind),
        .en      (en_pj),
        .matrix  (op.matrix),
        .top     (top_pj),
        .refused (refused_pj)
    );

    ////////////////////////////////////////////////////////////////////////////
    // status, same edge as the stack update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            st_valid <= 1'b0;
            st_err   <= 1'b0;
        end
        else
        begin
            st_valid <= op.valid;
            st_mode  <= op.mode;
            st_err   <= op.valid && (op.mode ? refused_pj : refused_mv);
        end
    end

    // tops come straight off the stacks, already past this op's update
    assign status.valid  = st_valid;
    assign status.mode   = st_mode;
    assign status.err    = st_err;
    assign status.mv_top = top_mv;
    assign status.pj_top = top_pj;

endmodule

//--- hdl/matrix_result.sv
module matrix_result
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  matrix_pkg::mat_status_t status,
    output matrix_pkg::matrix_t     top_matrix,
    output logic                    top_mode,
    output logic                    done,
    output logic                    err
);

    matrix_pkg::matrix_t sel_top;               // top of the stack just touched

    assign sel_top = status.mode ? status.pj_top : status.mv_top;

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            done <= 1'b0;
            err  <= 1'b0;
        end
        else
        begin
            done <= status.valid;               // one cycle per command
            err  <= status.valid && status.err;
            if (status.valid)
            begin
                top_matrix <= sel_top;          // held until the next command
                top_mode   <= status.mode;
            end
        end
    end

endmodule

//--- hdl/matrix_ctrl_top.sv
module matrix_ctrl_top
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cmd_valid,
    input  matrix_pkg::mat_opcode_t cmd_op,
    input  logic                    cmd_mode,
    input  matrix_pkg::matrix_t     cmd_rows,
    output matrix_pkg::matrix_t     top_matrix,
    output logic                    top_mode,
    output logic                    done,
    output logic                    err
);

    matrix_pkg::mat_op_t     op;                // decode -> execute
    matrix_pkg::mat_status_t status;            // execute -> result

    ////////////////////////////////////////////////////////////////////////////
    // decode, execute, result, one register stage each
    ////////////////////////////////////////////////////////////////////////////

    matrix_cmd_decode u_decode
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_mode  (cmd_mode),
        .cmd_rows  (cmd_rows),
        .op        (op)
    );

    matrix_exec u_exec
    (
        .clk    (clk),
        .arst_n (arst_n),
        .op     (op),
        .status (status)
    );

    matrix_result u_result
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .status     (status),
        .top_matrix (top_matrix),
        .top_mode   (top_mode),
        .done       (done),
        .err        (err)
    );

endmodule

//--- test/tb_matrix_model.svh
`ifndef TB_MATRIX_MODEL_SVH
`define TB_MATRIX_MODEL_SVH

    ////////////////////////////////////////////////////////////////////////////
    // reference model of both stacks
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed
    {
        logic                issued;            // command reached a stack
        matrix_pkg::matrix_t top;
        logic                mode;
        logic                err;
    } expect_t;

    matrix_pkg::matrix_t mv_stack [$];          // last entry is the top
    matrix_pkg::matrix_t pj_stack [$];
    matrix_pkg::row_t    ld_rows [$];           // rows of a partial load
    logic                ld_mode;

    task automatic reset_model();
        mv_stack.delete();
        pj_stack.delete();
        mv_stack.push_back(matrix_pkg::IDENTITY);
        pj_stack.push_back(matrix_pkg::IDENTITY);
        ld_rows.delete();
        ld_mode = 1'b0;
    endtask

    // applies one issued command, returns what done should show for it
    function automatic expect_t predict_command(input matrix_pkg::mat_opcode_t opc,
                                                input logic mode,
                                                input matrix_pkg::matrix_t rows);
        expect_t             e;
        matrix_pkg::matrix_t stk [$];
        matrix_pkg::matrix_t pushed;
        if (mode)
            stk = pj_stack;
        else
            stk = mv_stack;
        e.issued = 1'b1;
        e.mode   = mode;
        e.err    = 1'b0;
        if (opc == matrix_pkg::OP_LOAD)
        begin
            if ((ld_rows.size() != 0) && (mode != ld_mode))
                ld_rows.delete();               // mode change, start over
            if (ld_rows.size() < 3)
            begin
                ld_rows.push_back(rows[0]);
                ld_mode  = mode;
                e.issued = 1'b0;                // no result until the fourth row
            end
            else
            begin
                pushed = {ld_rows[0], ld_rows[1], ld_rows[2], rows[0]};
                if (stk.size() == matrix_pkg::STACK_DEPTH)
                    e.err = 1'b1;               // full, refused
                else
                    stk.push_back(pushed);
                ld_rows.delete();
            end
        end
        else
        begin
            ld_rows.delete();                   // anything else abandons a load
            case (opc)
                matrix_pkg::OP_POP:
                begin
                    if (stk.size() == 1)
                        e.err = 1'b1;
                    else
                        stk.delete(stk.size() - 1);
                end
                matrix_pkg::OP_LOAD_ID:
                    stk[stk.size() - 1] = matrix_pkg::IDENTITY;
                matrix_pkg::OP_WRITE:
                    stk[stk.size() - 1] = rows;
                default:
                    e.err = 1'b0;               // nop
            endcase
        end
        e.top = stk[stk.size() - 1];
        if (mode)
            pj_stack = stk;
        else
            mv_stack = stk;
        return e;
    endfunction

`endif

//--- test/tb_matrix_ctrl.sv
module tb_matrix_ctrl;

    logic                    clk;
    logic                    arst_n;
    logic                    cmd_valid;
    matrix_pkg::mat_opcode_t cmd_op;
    logic                    cmd_mode;
    matrix_pkg::matrix_t     cmd_rows;
    matrix_pkg::matrix_t     top_matrix;
    logic                    top_mode;
    logic                    done;
    logic                    err;

    `include "tb_matrix_model.svh"

    expect_t     exp_q [$];                     // predictions in command order
    time         issue_q [$];                   // drive time of each predicted command
    expect_t     cmp_exp;
    int          lat_cycles;
    int          checks;
    int          errors;
    int          test_num;
    string       test_name;
    int          test_err_base;
    int          test_chk_base;

    matrix_ctrl_top u_dut
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_mode   (cmd_mode),
        .cmd_rows   (cmd_rows),
        .top_matrix (top_matrix),
        .top_mode   (top_mode),
        .done       (done),
        .err        (err)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // result checker samples outputs on the edge after they settle
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (done)
        begin
            if (exp_q.size() == 0)
            begin
                $display("done pulse arrived with no command outstanding");
                errors++;
            end
            else
            begin
                cmp_exp    = exp_q.pop_front();
                lat_cycles = int'(($time - issue_q.pop_front()) / 20);
                checks++;
                // drive edge, sampling edge, then exec and result stages
                assert (lat_cycles == 4)
                else
                begin
                    $display("MISMATCH done latency got %h expected %h", lat_cycles, 4);
                    errors++;
                end
                assert (top_matrix == cmp_exp.top)
                else
                begin
                    $display("MISMATCH top_matrix got %h expected %h", top_matrix, cmp_exp.top);
                    errors++;
                end
                assert (top_mode == cmp_exp.mode)
                else
                begin
                    $display("MISMATCH top_mode got %h expected %h", top_mode, cmp_exp.mode);
                    errors++;
                end
                assert (err == cmp_exp.err)
                else
                begin
                    $display("MISMATCH err got %h expected %h", err, cmp_exp.err);
                    errors++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic matrix_pkg::matrix_t random_matrix();
        logic [511:0] flat;
        flat = '0;
        for (int k = 0; k < 16; k++)
            flat = {flat[479:0], $urandom};
        return matrix_pkg::matrix_t'(flat);
    endfunction

    task automatic send_cmd(input matrix_pkg::mat_opcode_t opc, input logic mode,
                            input matrix_pkg::matrix_t rows);
        expect_t e;
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= opc;
        cmd_mode  <= mode;
        cmd_rows  <= rows;
        e = predict_command(opc, mode, rows);
        if (e.issued)
        begin
            exp_q.push_back(e);
            issue_q.push_back($time);
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    // rows first..last-1 of m with junk in the unused rows
    task automatic load_rows(input matrix_pkg::matrix_t m, input logic mode,
                             input int first, input int last);
        matrix_pkg::matrix_t rows;
        for (int i = first; i < last; i++)
        begin
            rows    = random_matrix();
            rows[0] = m[i[1:0]];
            send_cmd(matrix_pkg::OP_LOAD, mode, rows);
        end
    endtask

    task automatic finish_run();
        if (exp_q.size() != 0)
        begin
            $display("%0d expected results never arrived", exp_q.size());
            errors++;
        end
        $display("results checked %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    task automatic drain_results(input int limit);
        int n;
        idle_cycle();
        n = 0;
        while ((exp_q.size() != 0) && (n < limit))
        begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0)
        begin
            $display("timeout, %0d results still pending after %0d cycles",
                     exp_q.size(), limit);
            errors++;
            exp_q.delete();                     // next test starts from an empty queue
            issue_q.delete();
        end
        repeat (4) @(negedge clk);              // a stray done lands in this test
    endtask

    task automatic begin_test(input int num, input string name);
        test_num      = num;
        test_name     = name;
        test_err_base = errors;
        test_chk_base = checks;
    endtask

    task automatic close_test();
        drain_results(40);
        $display("test %0d %s: %s, %0d results, %0d errors", test_num, test_name,
                 (errors == test_err_base) ? "ok" : "FAIL",
                 checks - test_chk_base, errors - test_err_base);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        matrix_pkg::matrix_t     m_a;
        matrix_pkg::matrix_t     m_b;
        matrix_pkg::mat_opcode_t opc;
        logic [31:0]             r;
        logic                    mode;
        void'($urandom(24));
        clk       = 1'b0;
        arst_n    = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = matrix_pkg::OP_NOP;
        cmd_mode  = 1'b0;
        cmd_rows  = '0;
        checks    = 0;
        errors    = 0;
        reset_model();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        begin_test(1, "reset state");
        send_cmd(matrix_pkg::OP_NOP, 1'b0, '0);
        send_cmd(matrix_pkg::OP_NOP, 1'b1, '0);
        close_test();

        begin_test(2, "load and pop");
        m_a = random_matrix();
        load_rows(m_a, 1'b0, 0, 2);
        idle_cycle();                           // pause mid load
        load_rows(m_a, 1'b0, 2, 4);
        send_cmd(matrix_pkg::OP_NOP, 1'b1, '0); // other stack untouched
        send_cmd(matrix_pkg::OP_POP, 1'b0, '0);
        close_test();

        begin_test(3, "write and load identity");
        m_b = random_matrix();
        send_cmd(matrix_pkg::OP_WRITE, 1'b1, m_b);
        send_cmd(matrix_pkg::OP_POP, 1'b1, '0);        // depth still 1
        send_cmd(matrix_pkg::OP_LOAD_ID, 1'b1, random_matrix());
        send_cmd(matrix_pkg::OP_POP, 1'b1, '0);
        close_test();

        begin_test(4, "full and empty refusal");
        load_rows(random_matrix(), 1'b0, 0, 4);
        load_rows(random_matrix(), 1'b0, 0, 4);         // stack full
        send_cmd(matrix_pkg::OP_POP, 1'b0, '0);
        send_cmd(matrix_pkg::OP_POP, 1'b0, '0);
        close_test();

        begin_test(5, "abandoned loads");
        load_rows(random_matrix(), 1'b0, 0, 2);
        send_cmd(matrix_pkg::OP_NOP, 1'b0, '0);
        load_rows(random_matrix(), 1'b0, 0, 3);
        send_cmd(matrix_pkg::OP_WRITE, 1'b0, random_matrix());
        send_cmd(matrix_pkg::OP_POP, 1'b0, '0);
        load_rows(random_matrix(), 1'b0, 0, 2);
        load_rows(random_matrix(), 1'b1, 0, 4);         // mode change restarts
        send_cmd(matrix_pkg::OP_POP, 1'b0, '0);
        send_cmd(matrix_pkg::OP_POP, 1'b1, '0);
        close_test();

        begin_test(6, "random stream");
        mode = 1'b0;
        for (int i = 0; i < 300; i++)
        begin
            r = $urandom;
            if (r[7:5] == 3'd0)
                mode = ~mode;                   // occasional switch so loads mostly finish
            case (r[2:0])
                3'd4:    opc = matrix_pkg::OP_POP;
                3'd5:    opc = matrix_pkg::OP_LOAD_ID;
                3'd6:    opc = matrix_pkg::OP_WRITE;
                3'd7:    opc = matrix_pkg::OP_NOP;
                default: opc = matrix_pkg::OP_LOAD;
            endcase
            send_cmd(opc, mode, random_matrix());
        end
        close_test();

        finish_run();
    end

endmodule

//--- src.f
+incdir+test
hdl/matrix_pkg.sv
hdl/matrix_cmd_decode.sv
hdl/matrix_stack.sv
hdl/matrix_exec.sv
hdl/matrix_result.sv
hdl/matrix_ctrl_top.sv
test/tb_matrix_ctrl.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_matrix_ctrl -f src.f

out=$(./obj_dir/Vtb_matrix_ctrl)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Regression passed"
